/* hdl/load_cache.sv */
`default_nettype none

`include "load_defines.svh"

module load_cache (
    input  logic               clk_i,
    input  logic               rst_n_i,

    input  logic               cache_read_i,
    input  logic [`XLEN - 1:0] cache_address_i,
    output logic               cache_data_valid_o,
    output logic [`XLEN - 1:0] cache_data_o,

    mem_bus_if.responder       bus,

    output logic               ext_request_o,
    output logic [`XLEN - 1:0] ext_address_o,
    input  logic               ext_acknowledge_i,
    input  logic               ext_data_valid_i,
    input  logic [`XLEN - 1:0] ext_data_i
);

    localparam int unsigned INDEX_BITS = `CACHE_INDEX_BITS;
    localparam int unsigned TAG_BITS   = `CACHE_TAG_BITS;

    typedef enum logic [1:0] {LOOKUP, REFILL, RESPOND} state_t;

    state_t                  state_q, state_d;
    logic                    refill_req_q, refill_req_d;
    logic [`CACHE_LINES-1:0] valid_q;
    logic [TAG_BITS - 1:0]   tag_q [`CACHE_LINES];
    logic [`XLEN - 1:0]      data_q [`CACHE_LINES];
    logic [`XLEN - 1:0]      resp_data_q;

    logic [INDEX_BITS - 1:0] index;
    logic [TAG_BITS - 1:0]   tag;
    logic                    hit;
    logic                    refilling;
    logic                    line_write;

    assign index = cache_address_i[INDEX_BITS + 1:2];
    assign tag   = cache_address_i[`XLEN - 1:INDEX_BITS + 2];
    assign hit   = valid_q[index] && (tag_q[index] == tag);

    assign refilling  = (state_q == REFILL);
    assign line_write = refilling && ext_data_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= LOOKUP;
            refill_req_q <= 1'b0;
            valid_q      <= '0;
        end else begin
            state_q      <= state_d;
            refill_req_q <= refill_req_d;
            if (line_write) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (line_write) begin
            tag_q[index]  <= tag;
            data_q[index] <= ext_data_i;
            resp_data_q   <= ext_data_i;
        end else if (state_q == LOOKUP && cache_read_i && hit) begin
            resp_data_q <= data_q[index];
        end
    end

    always_comb begin
        state_d      = state_q;
        refill_req_d = refill_req_q;

        case (state_q)
            LOOKUP: begin
                if (cache_read_i) begin
                    if (hit) begin
                        state_d = RESPOND;
                    end else begin
                        state_d      = REFILL;
                        refill_req_d = 1'b1;
                    end
                end
            end

            REFILL: begin
                if (ext_acknowledge_i) begin
                    refill_req_d = 1'b0;
                end
                if (ext_data_valid_i) begin
                    state_d = RESPOND;
                end
            end

            default: state_d = LOOKUP;
        endcase
    end

    assign cache_data_valid_o = (state_q == RESPOND);
    assign cache_data_o       = resp_data_q;

    // the refill owns the external port and uncached traffic passes straight through otherwise
    // refills always fetch the whole aligned word
    assign ext_request_o = refilling ? refill_req_q : bus.request;
    assign ext_address_o = refilling ? {cache_address_i[`XLEN - 1:2], 2'b00} : bus.address;

    assign bus.acknowledge = !refilling && ext_acknowledge_i;
    assign bus.data_valid  = !refilling && ext_data_valid_i;
    assign bus.data        = ext_data_i;

endmodule : load_cache

`default_nettype wire

/* hdl/load_defines.svh */
`ifndef LOAD_DEFINES_SVH
`define LOAD_DEFINES_SVH

// data and address width of the core
`define XLEN 32

// the cachable regions of the memory map have inclusive bounds
`define CODE_REGION_START    32'h0000_0000
`define CODE_REGION_END      32'h0000_0FFF

`define INT_NVM_REGION_START 32'h0001_0000
`define INT_NVM_REGION_END   32'h0001_0FFF

// direct-mapped cache with one word per line
`define CACHE_LINES      16
`define CACHE_INDEX_BITS 4

// the two low address bits select the byte inside the word
`define CACHE_TAG_BITS   (`XLEN - `CACHE_INDEX_BITS - 2)

`endif

/* hdl/load_pkg.sv */
`default_nettype none

`include "load_defines.svh"

package load_pkg;

    // LBU and LHU are kept apart from the signed codes
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW
    } load_operation_t;

    // side information that rides along with the load
    typedef struct packed {
        logic [4:0] rd;
        logic [3:0] instr_id;
    } instr_packet_t;

    // true when addr lies in [start_addr, end_addr]
    function automatic logic inside_range(
        input logic [`XLEN - 1:0] start_addr,
        input logic [`XLEN - 1:0] end_addr,
        input logic [`XLEN - 1:0] addr
    );
        return (addr >= start_addr) && (addr <= end_addr);
    endfunction : inside_range

endpackage : load_pkg

`default_nettype wire

/* hdl/load_subsystem.sv */
`default_nettype none

`include "load_defines.svh"

module load_subsystem import load_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               valid_operation_i,
    input  logic [`XLEN - 1:0] load_address_i,
    input  load_operation_t    operation_i,
    input  instr_packet_t      instr_packet_i,

    output instr_packet_t      instr_packet_o,
    output logic [`XLEN - 1:0] loaded_data_o,
    output logic [`XLEN - 1:0] load_address_o,
    output logic               idle_o,
    output logic               data_valid_o,

    output logic               ext_request_o,
    output logic [`XLEN - 1:0] ext_address_o,
    input  logic               ext_acknowledge_i,
    input  logic               ext_data_valid_i,
    input  logic [`XLEN - 1:0] ext_data_i
);

    // cache read path between the two blocks
    logic               cache_read;
    logic [`XLEN - 1:0] cache_address;
    logic               cache_data_valid;
    logic [`XLEN - 1:0] cache_data;

    // uncached transfers from the load unit
    mem_bus_if uncached_bus ();

    load_unit u_load_unit (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .valid_operation_i  (valid_operation_i),
        .load_address_i     (load_address_i),
        .operation_i        (operation_i),
        .instr_packet_i     (instr_packet_i),
        .instr_packet_o     (instr_packet_o),
        .loaded_data_o      (loaded_data_o),
        .load_address_o     (load_address_o),
        .idle_o             (idle_o),
        .data_valid_o       (data_valid_o),
        .mem                (uncached_bus.requester),
        .cache_read_o       (cache_read),
        .cache_address_o    (cache_address),
        .cache_data_valid_i (cache_data_valid),
        .cache_data_i       (cache_data)
    );

    load_cache u_load_cache (
        .clk_i              (clk_i),
        .rst_n_i            (rst_n_i),
        .cache_read_i       (cache_read),
        .cache_address_i    (cache_address),
        .cache_data_valid_o (cache_data_valid),
        .cache_data_o       (cache_data),
        .bus                (uncached_bus.responder),
        .ext_request_o      (ext_request_o),
        .ext_address_o      (ext_address_o),
        .ext_acknowledge_i  (ext_acknowledge_i),
        .ext_data_valid_i   (ext_data_valid_i),
        .ext_data_i         (ext_data_i)
    );

endmodule : load_subsystem

`default_nettype wire

/* hdl/load_unit.sv */
`default_nettype none

`include "load_defines.svh"

module load_unit import load_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               valid_operation_i,
    input  logic [`XLEN - 1:0] load_address_i,
    input  load_operation_t    operation_i,
    input  instr_packet_t      instr_packet_i,

    output instr_packet_t      instr_packet_o,
    output logic [`XLEN - 1:0] loaded_data_o,
    output logic [`XLEN - 1:0] load_address_o,
    output logic               idle_o,
    output logic               data_valid_o,

    mem_bus_if.requester       mem,

    output logic               cache_read_o,
    output logic [`XLEN - 1:0] cache_address_o,
    input  logic               cache_data_valid_i,
    input  logic [`XLEN - 1:0] cache_data_i
);

    typedef enum logic [1:0] {IDLE, WAIT_CACHE, WAIT_MEMORY, DATA_VALID} state_t;

    state_t             state_q, state_d;
    logic               cache_read_q, cache_read_d;
    logic               request_q, request_d;
    logic [`XLEN - 1:0] load_data_q, load_data_d;
    logic [`XLEN - 1:0] load_address_q;
    load_operation_t    operation_q;
    logic               cachable;
    logic               accept;

    // routing is decided on the incoming address
    assign cachable = inside_range(`CODE_REGION_START, `CODE_REGION_END, load_address_i) |
                      inside_range(`INT_NVM_REGION_START, `INT_NVM_REGION_END, load_address_i);

    // the unit is free again once the result is on the outputs
    assign idle_o = (state_q == IDLE) || (state_q == DATA_VALID);
    assign accept = valid_operation_i && idle_o;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q      <= IDLE;
            cache_read_q <= 1'b0;
            request_q    <= 1'b0;
        end else begin
            state_q      <= state_d;
            cache_read_q <= cache_read_d;
            request_q    <= request_d;
        end
    end

    always_ff @(posedge clk_i) begin
        load_data_q <= load_data_d;
        if (accept) begin
            load_address_q <= load_address_i;
            operation_q    <= operation_i;
            instr_packet_o <= instr_packet_i;
        end
    end

    always_comb begin
        state_d      = state_q;
        cache_read_d = cache_read_q;
        request_d    = request_q;
        load_data_d  = load_data_q;

        case (state_q)
            IDLE, DATA_VALID: begin
                state_d = IDLE;
                if (accept) begin
                    if (cachable) begin
                        state_d      = WAIT_CACHE;
                        cache_read_d = 1'b1;
                    end else begin
                        state_d   = WAIT_MEMORY;
                        request_d = 1'b1;
                    end
                end
            end

            WAIT_CACHE: begin
                if (cache_data_valid_i) begin
                    state_d      = DATA_VALID;
                    cache_read_d = 1'b0;
                    load_data_d  = cache_data_i;
                end
            end

            // acknowledge and data may arrive in the same cycle
            WAIT_MEMORY: begin
                if (mem.acknowledge) begin
                    request_d = 1'b0;
                end
                if (mem.data_valid) begin
                    state_d     = DATA_VALID;
                    load_data_d = mem.data;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    // lane selection and extension of the captured word
    always_comb begin
        loaded_data_o = load_data_q;

        case (operation_q)
            LB, LBU: begin
                logic [7:0] lane;
                case (load_address_q[1:0])
                    2'b00:   lane = load_data_q[7:0];
                    2'b01:   lane = load_data_q[15:8];
                    2'b10:   lane = load_data_q[23:16];
                    default: lane = load_data_q[31:24];
                endcase
                if (operation_q == LB) begin
                    loaded_data_o = {{(`XLEN - 8){lane[7]}}, lane};
                end else begin
                    loaded_data_o = {{(`XLEN - 8){1'b0}}, lane};
                end
            end

            LH, LHU: begin
                logic [15:0] half;
                half = load_address_q[1] ? load_data_q[31:16] : load_data_q[15:0];
                if (operation_q == LH) begin
                    loaded_data_o = {{(`XLEN - 16){half[15]}}, half};
                end else begin
                    loaded_data_o = {{(`XLEN - 16){1'b0}}, half};
                end
            end

            default: loaded_data_o = load_data_q;
        endcase
    end

    assign data_valid_o    = (state_q == DATA_VALID);
    assign load_address_o  = load_address_q;
    assign cache_read_o    = cache_read_q;
    assign cache_address_o = load_address_q;
    assign mem.request     = request_q;
    assign mem.address     = load_address_q;

endmodule : load_unit

`default_nettype wire

/* hdl/mem_bus_if.sv */
`default_nettype none

`include "load_defines.svh"

// one transfer is outstanding at a time and the request is held until acknowledge
interface mem_bus_if;

    logic                request;
    logic [`XLEN - 1:0]  address;
    logic                acknowledge;
    logic                data_valid;
    logic [`XLEN - 1:0]  data;

    modport requester (
        output request,
        output address,
        input  acknowledge,
        input  data_valid,
        input  data
    );

    modport responder (
        input  request,
        input  address,
        output acknowledge,
        output data_valid,
        output data
    );

endinterface : mem_bus_if

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module load_subsystem_tb -f sim.f -o load_subsystem_sim

output=$(./obj_dir/load_subsystem_sim)
echo "$output"

if echo "$output" | grep -q "TEST RESULT: PASS"; then
    exit 0
fi
exit 1

/* sim.f */
+incdir+hdl
hdl/load_pkg.sv
hdl/mem_bus_if.sv
hdl/load_unit.sv
hdl/load_cache.sv
hdl/load_subsystem.sv
verif/load_subsystem_checker.sv
verif/load_subsystem_tb.sv

/* verif/load_subsystem_checker.sv */
`default_nettype none

module load_subsystem_checker (
    input logic clk_i,
    input logic rst_n_i,
    input logic data_valid_i,
    input logic ext_request_i,
    input logic ext_acknowledge_i,
    input logic cache_read_i,
    input logic uncached_request_i
);

    timeunit 1ns;
    timeprecision 1ps;

    // every result is a single-cycle pulse
    data_valid_pulse: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        data_valid_i |=> !data_valid_i
    ) else $error("data_valid_o stayed high for two cycles");

    // the memory port keeps its request up until the memory takes it
    request_held: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ext_request_i && !ext_acknowledge_i |=> ext_request_i
    ) else $error("external request dropped before acknowledge");

    // a load goes either through the cache or around it but never both
    single_path: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        !(cache_read_i && uncached_request_i)
    ) else $error("cache read and uncached request active together");

    // reset leaves no result on the outputs
    quiet_after_reset: assert property (
        @(posedge clk_i)
        !rst_n_i |=> !data_valid_i
    ) else $error("data_valid_o high in the cycle after reset");

endmodule : load_subsystem_checker

bind load_subsystem load_subsystem_checker u_checker (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .data_valid_i       (data_valid_o),
    .ext_request_i      (ext_request_o),
    .ext_acknowledge_i  (ext_acknowledge_i),
    .cache_read_i       (cache_read),
    .uncached_request_i (uncached_bus.request)
);

`default_nettype wire

/* verif/load_subsystem_tb.sv */
`default_nettype none

`include "load_defines.svh"

module load_subsystem_tb import load_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DIRECTED_LOADS = 4;
    localparam int LANE_LOADS     = 32;
    localparam int RANDOM_LOADS   = 20;
    // every load finishes within 10 cycles and the extra 50 cover reset and the end of the run
    localparam int MAX_CYCLES = (DIRECTED_LOADS + LANE_LOADS + RANDOM_LOADS) * 10 + 50;
    localparam logic [`XLEN - 1:0] WORD_MASK = 32'hA5C3_5A3C;

    typedef struct packed {
        logic [`XLEN - 1:0] address;
        logic [`XLEN - 1:0] data;
        instr_packet_t      packet;
        logic               cachable;
        logic               hit;
    } expected_t;

    logic               clk_i;
    logic               rst_n_i;
    logic               valid_operation_i;
    logic [`XLEN - 1:0] load_address_i;
    load_operation_t    operation_i;
    instr_packet_t      instr_packet_i;
    instr_packet_t      instr_packet_o;
    logic [`XLEN - 1:0] loaded_data_o;
    logic [`XLEN - 1:0] load_address_o;
    logic               idle_o;
    logic               data_valid_o;
    logic               ext_request_o;
    logic [`XLEN - 1:0] ext_address_o;
    logic               ext_acknowledge_i;
    logic               ext_data_valid_i;
    logic [`XLEN - 1:0] ext_data_i;

    int                 seed = 32'hfd99;
    int                 errors = 0;
    int                 loads_checked = 0;
    int                 cycle_count = 0;
    int                 accept_cycle = 0;
    int                 load_requests = 0;
    logic               in_flight = 1'b0;
    expected_t          scoreboard [$];

    // testbench view of the cache contents with index bits 5:2 and tag bits 31:6
    logic               shadow_valid [`CACHE_LINES];
    logic [`XLEN - 1:6] shadow_tag [`CACHE_LINES];

    logic               mem_pending = 1'b0;
    logic [1:0]         mem_delay;
    logic [`XLEN - 1:0] mem_address;

    load_subsystem DUT (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .valid_operation_i (valid_operation_i),
        .load_address_i    (load_address_i),
        .operation_i       (operation_i),
        .instr_packet_i    (instr_packet_i),
        .instr_packet_o    (instr_packet_o),
        .loaded_data_o     (loaded_data_o),
        .load_address_o    (load_address_o),
        .idle_o            (idle_o),
        .data_valid_o      (data_valid_o),
        .ext_request_o     (ext_request_o),
        .ext_address_o     (ext_address_o),
        .ext_acknowledge_i (ext_acknowledge_i),
        .ext_data_valid_i  (ext_data_valid_i),
        .ext_data_i        (ext_data_i)
    );

    always #4 clk_i = ~clk_i;

    // memory holds one word per aligned address
    function automatic logic [`XLEN - 1:0] model_word(input logic [`XLEN - 1:0] address);
        return {address[`XLEN - 1:2], 2'b00} ^ WORD_MASK;
    endfunction

    // the code region starts at address zero
    function automatic logic is_cachable(input logic [`XLEN - 1:0] address);
        return (address <= `CODE_REGION_END) ||
               (address >= `INT_NVM_REGION_START && address <= `INT_NVM_REGION_END);
    endfunction

    function automatic logic [`XLEN - 1:0] expected_result(
        input logic [`XLEN - 1:0] address,
        input load_operation_t    op
    );
        logic [`XLEN - 1:0] word;
        logic [7:0]         lane;
        logic [15:0]        half;
        word = model_word(address);
        lane = word[8 * address[1:0] +: 8];
        half = address[1] ? word[31:16] : word[15:0];
        case (op)
            LB:      return {{24{lane[7]}}, lane};
            LBU:     return {24'h0, lane};
            LH:      return {{16{half[15]}}, half};
            LHU:     return {16'h0, half};
            default: return word;
        endcase
    endfunction

    task automatic issue_load(
        input logic [`XLEN - 1:0] address,
        input load_operation_t    op,
        input instr_packet_t      packet
    );
        expected_t  entry;
        logic [3:0] index;
        index          = address[5:2];
        entry.address  = address;
        entry.data     = expected_result(address, op);
        entry.packet   = packet;
        entry.cachable = is_cachable(address);
        entry.hit      = entry.cachable && shadow_valid[index] &&
                         (shadow_tag[index] == address[`XLEN - 1:6]);
        // a miss fills the line so the next load of that word hits
        if (entry.cachable) begin
            shadow_valid[index] = 1'b1;
            shadow_tag[index]   = address[`XLEN - 1:6];
        end
        scoreboard.push_back(entry);
        valid_operation_i = 1'b1;
        load_address_i    = address;
        operation_i       = op;
        instr_packet_i    = packet;
        @(posedge clk_i);
        #1;
        valid_operation_i = 1'b0;
        do begin
            @(posedge clk_i);
        end while (!data_valid_o);
        #1;
    endtask

    // the memory acknowledges at once and delivers data 0 to 3 cycles later
    always @(posedge clk_i) begin
        #1;
        ext_acknowledge_i = 1'b0;
        ext_data_valid_i  = 1'b0;
        if (mem_pending) begin
            if (mem_delay == 2'd0) begin
                ext_data_valid_i = 1'b1;
                ext_data_i       = model_word(mem_address);
                mem_pending      = 1'b0;
            end else begin
                mem_delay = mem_delay - 2'd1;
            end
        end else if (ext_request_o) begin
            ext_acknowledge_i = 1'b1;
            mem_address       = ext_address_o;
            mem_delay         = 2'($random(seed));
            if (mem_delay == 2'd0) begin
                ext_data_valid_i = 1'b1;
                ext_data_i       = model_word(mem_address);
            end else begin
                mem_pending = 1'b1;
                mem_delay   = mem_delay - 2'd1;
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout, the loads did not finish within %0d cycles", MAX_CYCLES);
            $display("loads checked %0d, errors %0d", loads_checked, errors);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    always @(posedge clk_i) begin : check_results
        expected_t entry;
        if (rst_n_i) begin
            // busy from acceptance up to the result cycle
            if (in_flight) begin
                assert (idle_o == data_valid_o) else begin
                    errors++;
                    $display("FAIL idle_o expected %h got %h", data_valid_o, idle_o);
                end
            end
            if (ext_request_o && ext_acknowledge_i) begin
                load_requests++;
                assert (in_flight && scoreboard.size() > 0) else begin
                    errors++;
                    $display("external request at %h with no load outstanding", ext_address_o);
                end
                if (in_flight && scoreboard.size() > 0) begin
                    entry = scoreboard[0];
                    assert (!entry.hit) else begin
                        errors++;
                        $display("external request for a load that should hit the cache");
                    end
                    assert (entry.cachable ?
                            ext_address_o[`XLEN - 1:2] == entry.address[`XLEN - 1:2] :
                            ext_address_o == entry.address) else begin
                        errors++;
                        $display("FAIL ext_address_o expected %h got %h",
                                 entry.address, ext_address_o);
                    end
                end
            end
            if (data_valid_o) begin
                assert (scoreboard.size() > 0) else begin
                    errors++;
                    $display("result delivered with no load outstanding");
                end
                if (scoreboard.size() > 0) begin
                    entry = scoreboard.pop_front();
                    loads_checked++;
                    assert (loaded_data_o == entry.data) else begin
                        errors++;
                        $display("FAIL loaded_data_o expected %h got %h",
                                 entry.data, loaded_data_o);
                    end
                    assert (instr_packet_o == entry.packet) else begin
                        errors++;
                        $display("FAIL instr_packet_o expected %h got %h",
                                 entry.packet, instr_packet_o);
                    end
                    assert (load_address_o == entry.address) else begin
                        errors++;
                        $display("FAIL load_address_o expected %h got %h",
                                 entry.address, load_address_o);
                    end
                    assert (load_requests == (entry.hit ? 0 : 1)) else begin
                        errors++;
                        $display("load at %h made %0d external requests",
                                 entry.address, load_requests);
                    end
                    if (entry.hit) begin
                        assert (cycle_count - accept_cycle == 3) else begin
                            errors++;
                            $display("cache hit took %0d cycles instead of 3",
                                     cycle_count - accept_cycle);
                        end
                    end
                end
                in_flight = 1'b0;
            end
            if (valid_operation_i && idle_o) begin
                in_flight     = 1'b1;
                accept_cycle  = cycle_count;
                load_requests = 0;
            end
        end
    end

    initial begin
        logic [`XLEN - 1:0] base;
        logic [`XLEN - 1:0] address;
        load_operation_t    op;
        instr_packet_t      packet;
        clk_i             = 1'b0;
        rst_n_i           = 1'b0;
        valid_operation_i = 1'b0;
        load_address_i    = '0;
        operation_i       = LW;
        instr_packet_i    = '0;
        ext_acknowledge_i = 1'b0;
        ext_data_valid_i  = 1'b0;
        ext_data_i        = '0;
        for (int i = 0; i < `CACHE_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            shadow_tag[i]   = '0;
        end
        repeat (3) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        @(posedge clk_i);
        assert (idle_o) else begin
            errors++;
            $display("FAIL idle_o expected 1 got %h", idle_o);
        end
        assert (!data_valid_o) else begin
            errors++;
            $display("FAIL data_valid_o expected 0 got %h", data_valid_o);
        end
        #1;

        // uncached word, a miss, a hit on that word and a new miss after it
        issue_load(32'h4000_0010, LW, 9'h011);
        issue_load(32'h0001_0024, LW, 9'h022);
        issue_load(32'h0001_0024, LW, 9'h033);
        issue_load(32'h0000_0800, LW, 9'h044);

        // each lane has its top bit clear in one word and set in the other
        for (int w = 0; w < 2; w++) begin
            base = (w == 0) ? 32'h0000_0100 : 32'h8080_8080;
            for (int off = 0; off < 4; off++) begin
                for (int k = 0; k < 4; k++) begin
                    issue_load(base + off, load_operation_t'(k), 9'(k + off * 4 + w * 16));
                end
            end
        end

        for (int n = 0; n < RANDOM_LOADS; n++) begin
            address = $random(seed);
            case (address[31:30])
                2'b00:   address = `CODE_REGION_START + {20'h0, address[11:0]};
                2'b01:   address = `INT_NVM_REGION_START + {20'h0, address[11:0]};
                default: address = {4'h2, address[27:0]};
            endcase
            op     = load_operation_t'(3'($unsigned($random(seed)) % 5));
            packet = 9'($random(seed));
            issue_load(address, op, packet);
        end

        $display("loads checked %0d, errors %0d", loads_checked, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : load_subsystem_tb

`default_nettype wire
